// File: brcp.f
source/brcp_pkg.sv
source/rename_map.sv
source/br_stack.sv
source/br_resolve.sv
source/brcp_top.sv
tb/brcp_tb.sv

// File: source/br_resolve.sv
`timescale 1ns/1ps

module br_resolve #(
    parameter int DEPTH = 4
) (
    input  logic                clock,
    input  logic                reset,

    // outcome of a branch from execute
    input  logic                resolve_valid,
    input  logic [DEPTH-1:0]    resolve_b_id,
    input  logic                resolve_mispredict,

    output brcp_pkg::br_task_t  br_task,
    output logic [DEPTH-1:0]    rem_b_id
);

    logic             pending;
    logic             mispredict_q;
    logic [DEPTH-1:0] b_id_q;

    // an outcome without an id names no entry, so it is dropped here
    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= resolve_valid & (|resolve_b_id);
        end
    end

    always_ff @(posedge clock) begin
        mispredict_q <= resolve_mispredict;
        b_id_q       <= resolve_b_id;
    end

    // stack command, one cycle after the outcome
    always_comb begin
        if (!pending) begin
            br_task = brcp_pkg::br_none;
        end else if (mispredict_q) begin
            br_task = brcp_pkg::br_squash;
        end else begin
            br_task = brcp_pkg::br_clear;
        end
    end

    assign rem_b_id = b_id_q;   // only looked at when br_task is not br_none

endmodule

// File: source/br_stack.sv
`timescale 1ns/1ps

module br_stack #(
    parameter int DEPTH = 4,
    parameter int N     = 2
) (
    input  logic                                              clock,
    input  logic                                              reset,

    input  logic                                              dispatch_valid,
    input  logic                                              dispatch_is_branch,

    // live rename state, saved on a branch dispatch
    input  brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0]    live_map,
    input  logic [brcp_pkg::phys_bits-1:0]                    fl_head,
    input  logic [brcp_pkg::rob_bits-1:0]                     rob_tail,

    input  logic [N-1:0]                                      cdb_valid,
    input  logic [N-1:0][brcp_pkg::phys_bits-1:0]             cdb_tag,
    input  logic [N-1:0][brcp_pkg::arch_bits-1:0]             cdb_reg,

    input  brcp_pkg::br_task_t                                br_task,
    input  logic [DEPTH-1:0]                                  rem_b_id,  // one-hot

    output logic [DEPTH-1:0]                                  assigned_b_id,
    output logic                                              full,
    output logic                                              cp_valid,
    output brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0]    cp_map,
    output logic [brcp_pkg::phys_bits-1:0]                    cp_fl_head,
    output logic [brcp_pkg::rob_bits-1:0]                     cp_rob_tail
);

    // control part of each entry
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] next_valid;
    logic [DEPTH-1:0] entry_b_id [DEPTH];
    logic [DEPTH-1:0] next_b_id  [DEPTH];
    logic [DEPTH-1:0] entry_mask [DEPTH];   // ids of older branches still in flight
    logic [DEPTH-1:0] next_mask  [DEPTH];

    // saved rename state
    brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0] saved_map [DEPTH];
    brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0] next_map  [DEPTH];
    logic [brcp_pkg::phys_bits-1:0] saved_fl_head  [DEPTH];
    logic [brcp_pkg::phys_bits-1:0] next_fl_head   [DEPTH];
    logic [brcp_pkg::rob_bits-1:0]  saved_rob_tail [DEPTH];
    logic [brcp_pkg::rob_bits-1:0]  next_rob_tail  [DEPTH];

    logic [DEPTH-1:0] free_entries;
    logic [DEPTH-1:0] stack_gnt;
    logic [DEPTH-1:0] older_ids;
    logic             alloc_en;

    assign free_entries = ~entry_valid;
    assign stack_gnt    = free_entries & (~free_entries + 1'b1);  // lowest set bit
    assign full         = ~|free_entries;

    // no allocation while a squash restores the rename stage
    assign alloc_en      = dispatch_valid & dispatch_is_branch & ~cp_valid;
    assign assigned_b_id = alloc_en ? stack_gnt : '0;   // zero when full

    // checkpoint readout for a mispredicted branch
    always_comb begin
        cp_valid    = 1'b0;
        cp_map      = '0;
        cp_fl_head  = '0;
        cp_rob_tail = '0;
        if (br_task == brcp_pkg::br_squash) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (entry_valid[i] && entry_b_id[i] == rem_b_id) begin
                    cp_valid    = 1'b1;
                    cp_map      = saved_map[i];
                    cp_fl_head  = saved_fl_head[i];
                    cp_rob_tail = saved_rob_tail[i];
                end
            end
        end
    end

    always_comb begin
        next_valid    = entry_valid;
        next_b_id     = entry_b_id;
        next_mask     = entry_mask;
        next_map      = saved_map;
        next_fl_head  = saved_fl_head;
        next_rob_tail = saved_rob_tail;
        older_ids     = '0;

        case (br_task)
            brcp_pkg::br_clear: begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (entry_valid[i] && entry_b_id[i] == rem_b_id) begin
                        next_valid[i] = 1'b0;
                        next_b_id[i]  = '0;
                        next_mask[i]  = '0;
                    end else begin
                        next_mask[i] = entry_mask[i] & ~rem_b_id;  // no longer depends on it
                    end
                end
            end
            brcp_pkg::br_squash: begin
                // the branch itself and everything younger goes
                for (int i = 0; i < DEPTH; i++) begin
                    if ((entry_mask[i] & rem_b_id) != '0 || entry_b_id[i] == rem_b_id) begin
                        next_valid[i] = 1'b0;
                        next_b_id[i]  = '0;
                        next_mask[i]  = '0;
                    end
                end
            end
            default: begin
            end
        endcase

        // freed entries hold a zero id, so this is the set still in flight
        for (int i = 0; i < DEPTH; i++) begin
            older_ids = older_ids | next_b_id[i];
        end

        for (int k = 0; k < DEPTH; k++) begin
            if (alloc_en && stack_gnt[k]) begin
                next_valid[k]    = 1'b1;
                next_b_id[k]     = stack_gnt;
                next_mask[k]     = older_ids;
                next_map[k]      = live_map;    // state from before this dispatch
                next_fl_head[k]  = fl_head;
                next_rob_tail[k] = rob_tail;
            end
        end

        // ready bits in every live checkpoint, new one included
        for (int l = 0; l < N; l++) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (cdb_valid[l] && next_valid[j] &&
                    next_map[j][cdb_reg[l]].tag == cdb_tag[l]) begin
                    next_map[j][cdb_reg[l]].ready = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entry_b_id[i] <= '0;
                entry_mask[i] <= '0;
            end
        end else begin
            entry_valid <= next_valid;
            entry_b_id  <= next_b_id;
            entry_mask  <= next_mask;
        end
    end

    // checkpoint payload, written on allocation and by the CDB
    always_ff @(posedge clock) begin
        saved_map      <= next_map;
        saved_fl_head  <= next_fl_head;
        saved_rob_tail <= next_rob_tail;
    end

endmodule

// File: source/brcp_pkg.sv
package brcp_pkg;

    // architectural register file
    localparam int arch_regs = 32;
    localparam int arch_bits = 5;   // index into the map table

    // physical register file, R10K style
    localparam int phys_regs = 64;
    localparam int phys_bits = 6;   // width of a physical tag

    // reorder buffer tail pointer
    localparam int rob_bits = 5;

    // one map table entry
    // tag names the physical register that holds the newest value,
    // ready goes high once the CDB has broadcast that tag
    typedef struct packed {
        logic [phys_bits-1:0] tag;
        logic                 ready;
    } map_entry_t;

    // command from resolution to the branch stack
    typedef enum logic [1:0] {
        br_none   = 2'd0,   // nothing resolving this cycle
        br_clear  = 2'd1,   // predicted correctly, drop the checkpoint
        br_squash = 2'd2    // mispredicted, restore and kill younger
    } br_task_t;

endpackage

// File: source/brcp_top.sv
`timescale 1ns/1ps

module brcp_top #(
    parameter int DEPTH = 4,    // branch stack entries
    parameter int N     = 2     // CDB lanes
) (
    input  logic                                    clock,
    input  logic                                    reset,

    input  logic                                    dispatch_valid,
    input  logic                                    dispatch_is_branch,
    input  logic                                    dispatch_has_dest,
    input  logic [brcp_pkg::arch_bits-1:0]          dispatch_dest,

    input  logic [N-1:0]                            cdb_valid,
    input  logic [N-1:0][brcp_pkg::phys_bits-1:0]   cdb_tag,
    input  logic [N-1:0][brcp_pkg::arch_bits-1:0]   cdb_reg,

    input  logic                                    resolve_valid,
    input  logic [DEPTH-1:0]                        resolve_b_id,
    input  logic                                    resolve_mispredict,

    input  logic [brcp_pkg::arch_bits-1:0]          lookup_reg,

    output logic [DEPTH-1:0]                        assigned_b_id,
    output logic                                    full,
    output logic [brcp_pkg::phys_bits-1:0]          lookup_tag,
    output logic                                    lookup_ready,
    output logic [brcp_pkg::phys_bits-1:0]          fl_head,
    output logic [brcp_pkg::rob_bits-1:0]           rob_tail
);

    brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0] live_map;
    brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0] cp_map;
    logic                                           cp_valid;
    logic [brcp_pkg::phys_bits-1:0]                 cp_fl_head;
    logic [brcp_pkg::rob_bits-1:0]                  cp_rob_tail;
    brcp_pkg::br_task_t                             br_task;
    logic [DEPTH-1:0]                               rem_b_id;

    rename_map #(
        .N(N)
    ) u_rename_map (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_has_dest (dispatch_has_dest),
        .dispatch_dest     (dispatch_dest),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_reg           (cdb_reg),
        .cp_valid          (cp_valid),
        .cp_map            (cp_map),
        .cp_fl_head        (cp_fl_head),
        .cp_rob_tail       (cp_rob_tail),
        .lookup_reg        (lookup_reg),
        .live_map          (live_map),
        .fl_head           (fl_head),
        .rob_tail          (rob_tail),
        .lookup_tag        (lookup_tag),
        .lookup_ready      (lookup_ready)
    );

    br_stack #(
        .DEPTH(DEPTH),
        .N    (N)
    ) u_br_stack (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_is_branch (dispatch_is_branch),
        .live_map           (live_map),
        .fl_head            (fl_head),
        .rob_tail           (rob_tail),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_reg            (cdb_reg),
        .br_task            (br_task),
        .rem_b_id           (rem_b_id),
        .assigned_b_id      (assigned_b_id),
        .full               (full),
        .cp_valid           (cp_valid),
        .cp_map             (cp_map),
        .cp_fl_head         (cp_fl_head),
        .cp_rob_tail        (cp_rob_tail)
    );

    br_resolve #(
        .DEPTH(DEPTH)
    ) u_br_resolve (
        .clock              (clock),
        .reset              (reset),
        .resolve_valid      (resolve_valid),
        .resolve_b_id       (resolve_b_id),
        .resolve_mispredict (resolve_mispredict),
        .br_task            (br_task),
        .rem_b_id           (rem_b_id)
    );

endmodule

// File: source/rename_map.sv
`timescale 1ns/1ps

module rename_map #(
    parameter int N = 2
) (
    input  logic                                              clock,
    input  logic                                              reset,

    // dispatch, one instruction per cycle
    input  logic                                              dispatch_valid,
    input  logic                                              dispatch_has_dest,
    input  logic [brcp_pkg::arch_bits-1:0]                    dispatch_dest,

    // result lanes of the CDB
    input  logic [N-1:0]                                      cdb_valid,
    input  logic [N-1:0][brcp_pkg::phys_bits-1:0]             cdb_tag,
    input  logic [N-1:0][brcp_pkg::arch_bits-1:0]             cdb_reg,

    // checkpoint restore from the branch stack
    input  logic                                              cp_valid,
    input  brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0]    cp_map,
    input  logic [brcp_pkg::phys_bits-1:0]                    cp_fl_head,
    input  logic [brcp_pkg::rob_bits-1:0]                     cp_rob_tail,

    input  logic [brcp_pkg::arch_bits-1:0]                    lookup_reg,

    output brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0]    live_map,
    output logic [brcp_pkg::phys_bits-1:0]                    fl_head,
    output logic [brcp_pkg::rob_bits-1:0]                     rob_tail,
    output logic [brcp_pkg::phys_bits-1:0]                    lookup_tag,
    output logic                                              lookup_ready
);

    brcp_pkg::map_entry_t [brcp_pkg::arch_regs-1:0] next_map;
    logic [brcp_pkg::phys_bits-1:0]                 next_fl_head;
    logic [brcp_pkg::rob_bits-1:0]                  next_rob_tail;
    logic                                           do_dispatch;

    // a squash in flight takes precedence, the dispatched slot is wrong-path
    assign do_dispatch = dispatch_valid & ~cp_valid;

    always_comb begin
        // base state: either the restored checkpoint or the live one
        if (cp_valid) begin
            next_map      = cp_map;
            next_fl_head  = cp_fl_head;
            next_rob_tail = cp_rob_tail;
        end else begin
            next_map      = live_map;
            next_fl_head  = fl_head;
            next_rob_tail = rob_tail;
        end

        // results broadcast this cycle, also applied on top of a restore
        // so that a same-cycle broadcast is not lost
        for (int l = 0; l < N; l++) begin
            if (cdb_valid[l] && next_map[cdb_reg[l]].tag == cdb_tag[l]) begin
                next_map[cdb_reg[l]].ready = 1'b1;
            end
        end

        if (do_dispatch) begin
            next_rob_tail = rob_tail + 1'b1;    // every instruction takes a ROB slot
            if (dispatch_has_dest) begin
                // free list head wraps at phys_regs by width
                next_map[dispatch_dest].tag   = fl_head;
                next_map[dispatch_dest].ready = 1'b0;
                next_fl_head                  = fl_head + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < brcp_pkg::arch_regs; i++) begin
                live_map[i] <= '{tag: '0, ready: 1'b1};
            end
            fl_head  <= '0;
            rob_tail <= '0;
        end else begin
            live_map <= next_map;
            fl_head  <= next_fl_head;
            rob_tail <= next_rob_tail;
        end
    end

    // read port sees the registered table only
    assign lookup_tag   = live_map[lookup_reg].tag;
    assign lookup_ready = live_map[lookup_reg].ready;

endmodule

// File: tb/brcp_tb.sv
`timescale 1ns/1ps

module brcp_tb;

    localparam int DEPTH        = 4;
    localparam int N            = 2;
    localparam int total_cycles = 450;   // reset, directed tests and random phase
    localparam int regs         = brcp_pkg::arch_regs;

    logic                                  clock;
    logic                                  reset;
    logic                                  dispatch_valid;
    logic                                  dispatch_is_branch;
    logic                                  dispatch_has_dest;
    logic [brcp_pkg::arch_bits-1:0]        dispatch_dest;
    logic [N-1:0]                          cdb_valid;
    logic [N-1:0][brcp_pkg::phys_bits-1:0] cdb_tag;
    logic [N-1:0][brcp_pkg::arch_bits-1:0] cdb_reg;
    logic                                  resolve_valid;
    logic [DEPTH-1:0]                      resolve_b_id;
    logic                                  resolve_mispredict;
    logic [brcp_pkg::arch_bits-1:0]        lookup_reg;
    logic [DEPTH-1:0]                      assigned_b_id;
    logic                                  full;
    logic [brcp_pkg::phys_bits-1:0]        lookup_tag;
    logic                                  lookup_ready;
    logic [brcp_pkg::phys_bits-1:0]        fl_head;
    logic [brcp_pkg::rob_bits-1:0]         rob_tail;

    // reference model of the rename stage and the branch stack
    logic [brcp_pkg::phys_bits-1:0] m_tag [regs];
    logic                           m_rdy [regs];
    logic [brcp_pkg::phys_bits-1:0] m_fl;
    logic [brcp_pkg::rob_bits-1:0]  m_rob;
    logic                           e_valid [DEPTH];
    logic [DEPTH-1:0]               e_mask  [DEPTH];
    logic [brcp_pkg::phys_bits-1:0] c_tag [DEPTH][regs];
    logic                           c_rdy [DEPTH][regs];
    logic [brcp_pkg::phys_bits-1:0] c_fl  [DEPTH];
    logic [brcp_pkg::rob_bits-1:0]  c_rob [DEPTH];
    logic                           pend_v;      // outcome waiting in br_resolve
    logic                           pend_mis;
    logic [DEPTH-1:0]               pend_id;

    logic [31:0]                    lfsr_state = 32'h4eab_a976;
    logic [brcp_pkg::phys_bits-1:0] saved_tags [regs];
    logic [brcp_pkg::phys_bits-1:0] saved_fl;
    logic [brcp_pkg::rob_bits-1:0]  saved_rob;

    brcp_top #(.DEPTH(DEPTH), .N(N)) dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(20 * total_cycles * 10);
        report_failure("watchdog timeout, the test did not finish in time");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("FAIL %s expected %h got %h", name, exp, act));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            result     = {result[30:0], fb};
        end
        return result;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < DEPTH; i++) begin
            if (!e_valid[i]) return i;
        end
        return -1;
    endfunction

    // entry restored this cycle, -1 when none
    function automatic int squash_index();
        if (pend_v && pend_mis) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (e_valid[i] && (1 << i) == pend_id) return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [DEPTH-1:0] expected_b_id();
        int gnt;
        gnt = lowest_free();
        if (dispatch_valid && dispatch_is_branch && squash_index() < 0 && gnt >= 0) begin
            return DEPTH'(1) << gnt;
        end
        return '0;
    endfunction

    task automatic reset_model();
        for (int r = 0; r < regs; r++) begin
            m_tag[r] = '0;
            m_rdy[r] = 1'b1;
        end
        for (int i = 0; i < DEPTH; i++) begin
            e_valid[i] = 1'b0;
            e_mask[i]  = '0;
        end
        m_fl     = '0;
        m_rob    = '0;
        pend_v   = 1'b0;
        pend_mis = 1'b0;
        pend_id  = '0;
    endtask

    // next state of the model for the inputs driven this cycle
    task automatic update_model();
        int               sq;
        int               gnt;
        logic [DEPTH-1:0] in_flight;
        sq        = squash_index();
        gnt       = lowest_free();
        in_flight = '0;
        if (sq >= 0) begin
            for (int r = 0; r < regs; r++) begin
                m_tag[r] = c_tag[sq][r];
                m_rdy[r] = c_rdy[sq][r];
            end
            m_fl  = c_fl[sq];
            m_rob = c_rob[sq];
            for (int i = 0; i < DEPTH; i++) begin
                if ((e_mask[i] & pend_id) != 0 || i == sq) begin   // it and younger
                    e_valid[i] = 1'b0;
                    e_mask[i]  = '0;
                end
            end
        end else begin
            if (pend_v && !pend_mis) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (e_valid[i] && (1 << i) == pend_id) begin
                        e_valid[i] = 1'b0;
                        e_mask[i]  = '0;
                    end else begin
                        e_mask[i] = e_mask[i] & ~pend_id;
                    end
                end
            end
            for (int i = 0; i < DEPTH; i++) begin
                in_flight[i] = e_valid[i];
            end
            if (dispatch_valid && dispatch_is_branch && gnt >= 0) begin
                for (int r = 0; r < regs; r++) begin
                    c_tag[gnt][r] = m_tag[r];
                    c_rdy[gnt][r] = m_rdy[r];
                end
                c_fl[gnt]    = m_fl;
                c_rob[gnt]   = m_rob;
                e_valid[gnt] = 1'b1;
                e_mask[gnt]  = in_flight;
            end
        end
        for (int l = 0; l < N; l++) begin
            if (cdb_valid[l]) begin
                if (m_tag[cdb_reg[l]] == cdb_tag[l]) m_rdy[cdb_reg[l]] = 1'b1;
                for (int i = 0; i < DEPTH; i++) begin
                    if (e_valid[i] && c_tag[i][cdb_reg[l]] == cdb_tag[l]) begin
                        c_rdy[i][cdb_reg[l]] = 1'b1;
                    end
                end
            end
        end
        if (sq < 0 && dispatch_valid) begin
            m_rob = m_rob + 1'b1;
            if (dispatch_has_dest) begin
                m_tag[dispatch_dest] = m_fl;
                m_rdy[dispatch_dest] = 1'b0;
                m_fl                 = m_fl + 1'b1;   // wraps at phys_regs
            end
        end
        pend_v   = resolve_valid && (|resolve_b_id);
        pend_id  = resolve_b_id;
        pend_mis = resolve_mispredict;
    endtask

    // called right after a falling edge with the inputs of this cycle set
    task automatic tick();
        #1;
        expect_eq("lookup_tag", m_tag[lookup_reg], lookup_tag);
        expect_eq("lookup_ready", m_rdy[lookup_reg], lookup_ready);
        expect_eq("fl_head", m_fl, fl_head);
        expect_eq("rob_tail", m_rob, rob_tail);
        expect_eq("full", lowest_free() < 0, full);
        expect_eq("assigned_b_id", expected_b_id(), assigned_b_id);
        update_model();
        @(negedge clock);
    endtask

    task automatic drive_idle();
        dispatch_valid     = 1'b0;
        dispatch_is_branch = 1'b0;
        dispatch_has_dest  = 1'b0;
        dispatch_dest      = '0;
        cdb_valid          = '0;
        cdb_tag            = '0;
        cdb_reg            = '0;
        resolve_valid      = 1'b0;
        resolve_b_id       = '0;
        resolve_mispredict = 1'b0;
    endtask

    task automatic dispatch_rename(input logic [brcp_pkg::arch_bits-1:0] dest);
        drive_idle();
        dispatch_valid    = 1'b1;
        dispatch_has_dest = 1'b1;
        dispatch_dest     = dest;
        tick();
    endtask

    task automatic dispatch_branch(input logic [DEPTH-1:0] exp_id);
        drive_idle();
        dispatch_valid     = 1'b1;
        dispatch_is_branch = 1'b1;
        #1;
        expect_eq("assigned_b_id", exp_id, assigned_b_id);
        tick();
    endtask

    task automatic resolve_branch(input logic [DEPTH-1:0] id, input logic mispredict);
        drive_idle();
        resolve_valid      = 1'b1;
        resolve_b_id       = id;
        resolve_mispredict = mispredict;
        tick();
        drive_idle();
        tick();   // stack acts on it during this cycle
    endtask

    task automatic clear_all();
        for (int i = 0; i < DEPTH; i++) begin
            if (e_valid[i]) resolve_branch(DEPTH'(1) << i, 1'b0);
        end
    endtask

    task automatic random_cycle();
        int start;
        int pick;
        int idx;
        drive_idle();
        lookup_reg = random_bits(5);
        if (random_bits(1)) begin
            dispatch_valid = 1'b1;
            if (random_bits(2) == 0 && lowest_free() >= 0) begin
                dispatch_is_branch = 1'b1;     // never while full
            end else begin
                dispatch_has_dest = random_bits(1);
                dispatch_dest     = random_bits(5);
            end
        end
        for (int l = 0; l < N; l++) begin
            if (random_bits(1)) begin
                cdb_valid[l] = 1'b1;
                cdb_reg[l]   = random_bits(5);
                cdb_tag[l]   = random_bits(1) ? m_tag[cdb_reg[l]] : random_bits(6);
            end
        end
        if (!pend_v && random_bits(2) == 0) begin
            start = random_bits(2);
            pick  = -1;
            for (int i = 0; i < DEPTH; i++) begin
                idx = (start + i) % DEPTH;
                if (e_valid[idx] && pick < 0) pick = idx;
            end
            if (pick >= 0) begin
                resolve_valid      = 1'b1;
                resolve_b_id       = DEPTH'(1) << pick;
                resolve_mispredict = (random_bits(2) == 0);
            end
        end
        tick();
    endtask

    initial begin
        reset = 1'b1;
        lookup_reg = '0;
        drive_idle();
        reset_model();
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // reset state of every map entry
        for (int r = 0; r < regs; r++) begin
            lookup_reg = r;
            tick();
        end

        // allocation order, full and a dropped branch
        for (int k = 0; k < DEPTH; k++) begin
            dispatch_branch(DEPTH'(1) << k);
        end
        expect_eq("full", 1, full);
        dispatch_branch('0);

        // correct resolution of a middle branch frees that entry only
        resolve_branch(4'b0010, 1'b0);
        expect_eq("full", 0, full);
        dispatch_branch(4'b0010);
        clear_all();

        // misprediction restores the state saved at the branch
        dispatch_rename(3);
        dispatch_rename(7);
        dispatch_branch(4'b0001);
        dispatch_rename(3);
        saved_fl  = m_fl;
        saved_rob = m_rob;
        for (int r = 0; r < regs; r++) begin
            saved_tags[r] = m_tag[r];
        end
        dispatch_branch(4'b0010);
        dispatch_rename(3);
        dispatch_rename(9);
        dispatch_branch(4'b0100);
        dispatch_rename(7);
        resolve_branch(4'b0010, 1'b1);
        expect_eq("fl_head", saved_fl, fl_head);
        expect_eq("rob_tail", saved_rob, rob_tail);
        for (int r = 0; r < regs; r++) begin
            lookup_reg = r;
            #1;
            expect_eq("lookup_tag", saved_tags[r], lookup_tag);
            tick();
        end
        dispatch_branch(4'b0010);
        dispatch_branch(4'b0100);
        clear_all();

        // ready from the CDB survives a restore, a wrong tag does nothing
        dispatch_rename(5);
        dispatch_rename(6);
        dispatch_branch(4'b0001);
        drive_idle();
        cdb_valid  = 2'b11;
        cdb_reg[1] = 5;
        cdb_tag[1] = m_tag[5];
        cdb_reg[0] = 6;
        cdb_tag[0] = m_tag[6] + 1'b1;
        tick();
        resolve_branch(4'b0001, 1'b1);
        lookup_reg = 5;
        #1;
        expect_eq("lookup_ready", 1, lookup_ready);
        tick();
        lookup_reg = 6;
        #1;
        expect_eq("lookup_ready", 0, lookup_ready);
        tick();

        repeat (300) random_cycle();

        $display("TEST PASS");
        $finish;
    end

endmodule
